/* common/backend_consts.svh */
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data path width.
`define XLEN 16

// reorder buffer geometry.
`define ROB_SIZE 8
`define ROB_TAG_LEN 3

`define REG_ADDR_LEN 4
`define TARGET_LEN 8

// issue word: two kind bits on top of a 46-bit payload.
`define INSTR_LEN 48

// fill bits that pad each payload view out to the full word.
`define ALU_PAD_LEN (`INSTR_LEN - 2 - 2 - `REG_ADDR_LEN - 2 * `XLEN)
`define BR_PAD_LEN (`INSTR_LEN - 2 - 3 - 2 * `XLEN - `TARGET_LEN)

// alu results waiting for the bus.
`define CDB_QUEUE_DEPTH 2

`endif

/* common/backend_pkg.sv */
`include "backend_consts.svh"

package backend_pkg;

    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_branch = 2'd1
    } instr_kind_e;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_and = 2'd2,
        op_xor = 2'd3
    } alu_op_e;

    // lt and ge compare the operands as unsigned values.
    typedef enum logic [1:0] {
        cond_eq = 2'd0,
        cond_ne = 2'd1,
        cond_lt = 2'd2,
        cond_ge = 2'd3
    } br_cond_e;

    typedef struct packed {
        alu_op_e                  op;
        logic [`REG_ADDR_LEN-1:0] dest;
        logic [`XLEN-1:0]         a;
        logic [`XLEN-1:0]         b;
        logic [`ALU_PAD_LEN-1:0]  pad;
    } alu_fields_t;

    typedef struct packed {
        br_cond_e               cond;
        logic                   predict_taken;
        logic [`BR_PAD_LEN-1:0] pad;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
        logic [`TARGET_LEN-1:0] target;
    } branch_fields_t;

    // the same payload bits, read by kind.
    typedef union packed {
        alu_fields_t    alu;
        branch_fields_t br;
    } instr_payload_u;

    typedef struct packed {
        instr_kind_e    kind;
        instr_payload_u payload;
    } instr_t;

endpackage

/* reorder_buffer/reorder_buffer.sv */
`timescale 1ns/1ps

`include "backend_consts.svh"

module reorder_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dispatch,
    input  logic                     has_dest,
    input  logic [`REG_ADDR_LEN-1:0] dest_reg,
    input  logic                     cdb_valid,
    input  logic [`ROB_TAG_LEN-1:0]  cdb_tag,
    input  logic [`XLEN-1:0]         cdb_data,
    input  logic [`XLEN-1:0]         cdb_target,
    input  logic                     cdb_mispredict,
    output logic [`ROB_TAG_LEN-1:0]  alloc_tag,
    output logic                     not_full,
    output logic                     commit_valid,
    output logic                     commit_wb_en,
    output logic [`REG_ADDR_LEN-1:0] commit_reg,
    output logic [`XLEN-1:0]         commit_data,
    output logic [`XLEN-1:0]         commit_target,
    output logic                     flush
);

    localparam int CNT_W = $clog2(`ROB_SIZE + 1);

    logic [`ROB_SIZE-1:0]     entry_valid;
    logic [`ROB_SIZE-1:0]     entry_ready;
    logic [`ROB_SIZE-1:0]     entry_has_dest;
    logic [`ROB_SIZE-1:0]     entry_mispredict;
    logic [`REG_ADDR_LEN-1:0] entry_reg [`ROB_SIZE];
    logic [`XLEN-1:0]         entry_data [`ROB_SIZE];
    logic [`XLEN-1:0]         entry_target [`ROB_SIZE];

    logic [`ROB_TAG_LEN-1:0] head;
    logic [`ROB_TAG_LEN-1:0] tail;
    logic [CNT_W-1:0]        count;
    logic                    allocate;
    logic                    retire;

    function automatic logic [`ROB_TAG_LEN-1:0] next_ptr(input logic [`ROB_TAG_LEN-1:0] ptr);
        if (ptr == `ROB_TAG_LEN'(`ROB_SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_full  = (count != CNT_W'(`ROB_SIZE));
    assign allocate  = dispatch && not_full;
    assign alloc_tag = tail;

    // the head retires as soon as its result has been written.
    assign commit_valid  = entry_valid[head] && entry_ready[head];
    assign commit_wb_en  = commit_valid && entry_has_dest[head];
    assign commit_reg    = entry_reg[head];
    assign commit_data   = entry_data[head];
    assign commit_target = entry_target[head];
    assign flush         = commit_valid && entry_mispredict[head];
    assign retire        = commit_valid;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            entry_valid <= '0;
            entry_ready <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
        end else begin
            if (allocate) begin
                entry_valid[tail] <= 1'b1;
                entry_ready[tail] <= 1'b0;
                tail              <= next_ptr(tail);
            end
            if (cdb_valid) begin
                entry_ready[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                entry_valid[head] <= 1'b0;
                head              <= next_ptr(head);
            end
            case ({allocate, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry contents are only looked at while the entry is valid.
    always_ff @(posedge clk) begin
        if (allocate) begin
            entry_has_dest[tail] <= has_dest;
            entry_reg[tail]      <= dest_reg;
        end
        if (cdb_valid) begin
            entry_data[cdb_tag]       <= cdb_data;
            entry_target[cdb_tag]     <= cdb_target;
            entry_mispredict[cdb_tag] <= cdb_mispredict;
        end
    end

endmodule

/* source/alu_unit.sv */
`timescale 1ns/1ps

`include "backend_consts.svh"

module alu_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    start,
    input  backend_pkg::alu_op_e    op,
    input  logic [`ROB_TAG_LEN-1:0] tag,
    input  logic [`XLEN-1:0]        a,
    input  logic [`XLEN-1:0]        b,
    output logic                    done,
    output logic [`ROB_TAG_LEN-1:0] done_tag,
    output logic [`XLEN-1:0]        result
);

    logic                    s1_valid;
    backend_pkg::alu_op_e    s1_op;
    logic [`ROB_TAG_LEN-1:0] s1_tag;
    logic [`XLEN-1:0]        s1_a;
    logic [`XLEN-1:0]        s1_b;
    logic [`XLEN-1:0]        s1_result;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    // stage one captures operands.
    always_ff @(posedge clk) begin
        if (start) begin
            s1_op  <= op;
            s1_tag <= tag;
            s1_a   <= a;
            s1_b   <= b;
        end
    end

    always_comb begin
        case (s1_op)
            backend_pkg::op_add: s1_result = s1_a + s1_b;
            backend_pkg::op_sub: s1_result = s1_a - s1_b;
            backend_pkg::op_and: s1_result = s1_a & s1_b;
            default:             s1_result = s1_a ^ s1_b;
        endcase
    end

    // stage two holds the result.
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            done_tag <= s1_tag;
            result   <= s1_result;
        end
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

`include "backend_consts.svh"

module branch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    start,
    input  backend_pkg::br_cond_e   cond,
    input  logic                    predict_taken,
    input  logic [`ROB_TAG_LEN-1:0] tag,
    input  logic [`XLEN-1:0]        a,
    input  logic [`XLEN-1:0]        b,
    input  logic [`TARGET_LEN-1:0]  target,
    output logic                    done,
    output logic [`ROB_TAG_LEN-1:0] done_tag,
    output logic [`XLEN-1:0]        target_out,
    output logic                    mispredict
);

    logic taken;

    always_comb begin
        case (cond)
            backend_pkg::cond_eq: taken = (a == b);
            backend_pkg::cond_ne: taken = (a != b);
            backend_pkg::cond_lt: taken = (a < b);
            default:              taken = (a >= b);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    // a not-taken branch reports a zero target.
    always_ff @(posedge clk) begin
        if (start) begin
            done_tag   <= tag;
            target_out <= taken ? {{(`XLEN - `TARGET_LEN){1'b0}}, target} : '0;
            mispredict <= (taken != predict_taken);
        end
    end

endmodule

/* source/cdb_arbiter.sv */
`timescale 1ns/1ps

`include "backend_consts.svh"

module cdb_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    alu_done,
    input  logic [`ROB_TAG_LEN-1:0] alu_tag,
    input  logic [`XLEN-1:0]        alu_result,
    input  logic                    br_done,
    input  logic [`ROB_TAG_LEN-1:0] br_tag,
    input  logic [`XLEN-1:0]        br_target,
    input  logic                    br_mispredict,
    output logic                    cdb_valid,
    output logic [`ROB_TAG_LEN-1:0] cdb_tag,
    output logic [`XLEN-1:0]        cdb_data,
    output logic [`XLEN-1:0]        cdb_target,
    output logic                    cdb_mispredict
);

    localparam int PTR_W = $clog2(`CDB_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`CDB_QUEUE_DEPTH + 1);

    logic [`ROB_TAG_LEN-1:0] q_tag [`CDB_QUEUE_DEPTH];
    logic [`XLEN-1:0]        q_data [`CDB_QUEUE_DEPTH];
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W-1:0]        wr_ptr;
    logic [CNT_W-1:0]        q_count;
    logic                    q_empty;
    logic                    q_push;
    logic                    q_pop;
    logic                    send_alu;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`CDB_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // branch first, then the oldest waiting alu result, then a fresh one.
    assign q_empty  = (q_count == '0);
    assign q_pop    = !br_done && !q_empty;
    assign q_push   = alu_done && (br_done || !q_empty);
    assign send_alu = alu_done && !br_done && q_empty;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            cdb_valid <= 1'b0;
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            q_count   <= '0;
        end else begin
            cdb_valid <= br_done || q_pop || send_alu;
            if (q_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (q_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            q_count <= q_count + CNT_W'(q_push) - CNT_W'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_tag[wr_ptr]  <= alu_tag;
            q_data[wr_ptr] <= alu_result;
        end
        if (br_done) begin
            cdb_tag        <= br_tag;
            cdb_data       <= '0;
            cdb_target     <= br_target;
            cdb_mispredict <= br_mispredict;
        end else if (q_pop) begin
            cdb_tag        <= q_tag[rd_ptr];
            cdb_data       <= q_data[rd_ptr];
            cdb_target     <= '0;
            cdb_mispredict <= 1'b0;
        end else if (send_alu) begin
            cdb_tag        <= alu_tag;
            cdb_data       <= alu_result;
            cdb_target     <= '0;
            cdb_mispredict <= 1'b0;
        end
    end

endmodule

/* source/ooo_backend.sv */
`timescale 1ns/1ps

`include "backend_consts.svh"

module ooo_backend (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  backend_pkg::instr_t      issue_instr,
    output logic                     issue_ready,
    output logic                     commit_valid,
    output logic                     commit_wb_en,
    output logic [`REG_ADDR_LEN-1:0] commit_reg,
    output logic [`XLEN-1:0]         commit_data,
    output logic [`XLEN-1:0]         commit_target,
    output logic                     flush
);

    backend_pkg::alu_fields_t    alu_f;
    backend_pkg::branch_fields_t br_f;

    logic                    accept;
    logic                    alu_start;
    logic                    br_start;
    logic [`ROB_TAG_LEN-1:0] alloc_tag;

    logic                    alu_done;
    logic [`ROB_TAG_LEN-1:0] alu_tag;
    logic [`XLEN-1:0]        alu_result;
    logic                    br_done;
    logic [`ROB_TAG_LEN-1:0] br_tag;
    logic [`XLEN-1:0]        br_target;
    logic                    br_mispredict;

    logic                    cdb_valid;
    logic [`ROB_TAG_LEN-1:0] cdb_tag;
    logic [`XLEN-1:0]        cdb_data;
    logic [`XLEN-1:0]        cdb_target;
    logic                    cdb_mispredict;

    assign alu_f = issue_instr.payload.alu;
    assign br_f  = issue_instr.payload.br;

    // a word of unknown kind is accepted and dropped without a tag.
    assign accept    = issue_valid && issue_ready;
    assign alu_start = accept && (issue_instr.kind == backend_pkg::kind_alu);
    assign br_start  = accept && (issue_instr.kind == backend_pkg::kind_branch);

    reorder_buffer reorder_buffer_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch(alu_start || br_start), .has_dest(alu_start), .dest_reg(alu_f.dest),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .cdb_target(cdb_target), .cdb_mispredict(cdb_mispredict),
        .alloc_tag(alloc_tag), .not_full(issue_ready),
        .commit_valid(commit_valid), .commit_wb_en(commit_wb_en), .commit_reg(commit_reg),
        .commit_data(commit_data), .commit_target(commit_target), .flush(flush)
    );

    alu_unit alu_unit_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .start(alu_start),
        .op(alu_f.op), .tag(alloc_tag), .a(alu_f.a), .b(alu_f.b),
        .done(alu_done), .done_tag(alu_tag), .result(alu_result)
    );

    branch_unit branch_unit_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .start(br_start),
        .cond(br_f.cond), .predict_taken(br_f.predict_taken), .tag(alloc_tag),
        .a(br_f.a), .b(br_f.b), .target(br_f.target),
        .done(br_done), .done_tag(br_tag), .target_out(br_target), .mispredict(br_mispredict)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_result(alu_result),
        .br_done(br_done), .br_tag(br_tag), .br_target(br_target),
        .br_mispredict(br_mispredict),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .cdb_target(cdb_target), .cdb_mispredict(cdb_mispredict)
    );

endmodule

/* test/ooo_backend_chk.sv */
`timescale 1ns/1ps

module ooo_backend_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                issue_valid,
    input logic                issue_ready,
    input backend_pkg::instr_t issue_instr,
    input logic                commit_valid,
    input logic                commit_wb_en,
    input logic                flush
);

    // only a retiring branch can flush, and a branch writes no register.
    flush_on_branch: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> commit_valid && !commit_wb_en)
        else $error("flush raised outside a branch commit");

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !commit_valid && !flush && issue_ready)
        else $error("buffer not empty after flush");

    known_kind: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && issue_ready |-> (issue_instr.kind == backend_pkg::kind_alu
                                        || issue_instr.kind == backend_pkg::kind_branch))
        else $error("issued word has an unknown kind");

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> !commit_valid && !flush && !commit_wb_en)
        else $error("commit outputs active after reset");

endmodule

/* test/ooo_backend_tb.sv */
`timescale 1ns/1ps

`include "backend_consts.svh"

module ooo_backend_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ISSUED   = 20 + 4 + 12 + 10;

    typedef struct packed {
        logic                     wb_en;
        logic [`REG_ADDR_LEN-1:0] dest;
        logic [`XLEN-1:0]         data;
        logic [`XLEN-1:0]         target;
        logic                     flush;
    } commit_t;

    logic                     clk;
    logic                     rst_n;
    logic                     issue_valid;
    backend_pkg::instr_t      issue_instr;
    logic                     issue_ready;
    logic                     commit_valid;
    logic                     commit_wb_en;
    logic [`REG_ADDR_LEN-1:0] commit_reg;
    logic [`XLEN-1:0]         commit_data;
    logic [`XLEN-1:0]         commit_target;
    logic                     flush;

    commit_t expected_q [$];
    string   test_name;

    ooo_backend ooo_backend_i (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_instr(issue_instr), .issue_ready(issue_ready),
        .commit_valid(commit_valid), .commit_wb_en(commit_wb_en), .commit_reg(commit_reg),
        .commit_data(commit_data), .commit_target(commit_target), .flush(flush)
    );

    bind ooo_backend ooo_backend_chk ooo_backend_chk_i (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .issue_instr(issue_instr), .commit_valid(commit_valid),
        .commit_wb_en(commit_wb_en), .flush(flush)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("MISMATCH %s %s: expected %0h, actual %0h",
                               test_name, what, expected, actual));
        end
    endtask

    function automatic logic branch_taken(input backend_pkg::br_cond_e cond,
                                          input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        case (cond)
            backend_pkg::cond_eq: return a == b;
            backend_pkg::cond_ne: return a != b;
            backend_pkg::cond_lt: return a < b;
            default:              return a >= b;
        endcase
    endfunction

    // reference model of what the buffer retires for one issued word.
    function automatic commit_t predict_commit(input backend_pkg::instr_t w);
        commit_t c;
        logic    taken;
        c = '0;
        if (w.kind == backend_pkg::kind_alu) begin
            c.wb_en = 1'b1;
            c.dest  = w.payload.alu.dest;
            case (w.payload.alu.op)
                backend_pkg::op_add: c.data = w.payload.alu.a + w.payload.alu.b;
                backend_pkg::op_sub: c.data = w.payload.alu.a - w.payload.alu.b;
                backend_pkg::op_and: c.data = w.payload.alu.a & w.payload.alu.b;
                default:             c.data = w.payload.alu.a ^ w.payload.alu.b;
            endcase
        end else begin
            taken    = branch_taken(w.payload.br.cond, w.payload.br.a, w.payload.br.b);
            c.target = taken ? `XLEN'(w.payload.br.target) : '0;
            c.flush  = (taken != w.payload.br.predict_taken);
        end
        return c;
    endfunction

    function automatic backend_pkg::instr_t make_alu(input backend_pkg::alu_op_e op,
            input logic [`REG_ADDR_LEN-1:0] dest, input logic [`XLEN-1:0] a,
            input logic [`XLEN-1:0] b);
        backend_pkg::instr_t w;
        w                 = '0;
        w.kind            = backend_pkg::kind_alu;
        w.payload.alu.op   = op;
        w.payload.alu.dest = dest;
        w.payload.alu.a    = a;
        w.payload.alu.b    = b;
        return w;
    endfunction

    function automatic backend_pkg::instr_t make_branch(input backend_pkg::br_cond_e cond,
            input logic predict, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
            input logic [`TARGET_LEN-1:0] target);
        backend_pkg::instr_t w;
        w                          = '0;
        w.kind                     = backend_pkg::kind_branch;
        w.payload.br.cond          = cond;
        w.payload.br.predict_taken = predict;
        w.payload.br.a             = a;
        w.payload.br.b             = b;
        w.payload.br.target        = target;
        return w;
    endfunction

    function automatic backend_pkg::instr_t random_alu();
        return make_alu(backend_pkg::alu_op_e'($urandom_range(3, 0)),
                        `REG_ADDR_LEN'($urandom), `XLEN'($urandom), `XLEN'($urandom));
    endfunction

    // correctly predicted, with equal operands now and then.
    function automatic backend_pkg::instr_t random_branch();
        backend_pkg::br_cond_e cond;
        logic [`XLEN-1:0]      a;
        logic [`XLEN-1:0]      b;
        cond = backend_pkg::br_cond_e'($urandom_range(3, 0));
        a    = `XLEN'($urandom);
        b    = ($urandom_range(1, 0) == 1) ? a : `XLEN'($urandom);
        return make_branch(cond, branch_taken(cond, a, b), a, b, `TARGET_LEN'($urandom));
    endfunction

    task automatic issue_word(input backend_pkg::instr_t w);
        logic accepted;
        accepted    = 1'b0;
        issue_valid = 1'b1;
        issue_instr = w;
        while (!accepted) begin
            @(negedge clk);
            accepted = issue_ready;
            @(posedge clk);
            #2;
        end
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic compare_commit();
        commit_t exp;
        if (expected_q.size() == 0) begin
            fail_run("commit_valid rose with no instruction outstanding");
        end else begin
            exp = expected_q.pop_front();
            check_value("commit_wb_en", `XLEN'(exp.wb_en), `XLEN'(commit_wb_en));
            if (exp.wb_en) begin
                check_value("commit_reg", `XLEN'(exp.dest), `XLEN'(commit_reg));
            end
            check_value("commit_data", exp.data, commit_data);
            check_value("commit_target", exp.target, commit_target);
            check_value("flush", `XLEN'(exp.flush), `XLEN'(flush));
            // everything still queued is younger than the flushing branch.
            if (exp.flush) begin
                expected_q.delete();
            end
        end
    endtask

    // commit and acceptance both refer to the coming rising edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (commit_valid) begin
                compare_commit();
            end
            if (issue_valid && issue_ready && !flush) begin
                expected_q.push_back(predict_commit(issue_instr));
            end
        end
    end

    task automatic test_reset_state();
        test_name = "reset_state";
        repeat (4) begin
            @(negedge clk);
            check_value("issue_ready", `XLEN'(1), `XLEN'(issue_ready));
            check_value("commit_valid", `XLEN'(0), `XLEN'(commit_valid));
            check_value("flush", `XLEN'(0), `XLEN'(flush));
            @(posedge clk);
            #2;
        end
    endtask

    task automatic test_alu_stream();
        test_name = "alu_stream";
        repeat (20) issue_word(random_alu());
        wait_drain();
    endtask

    task automatic test_alu_then_branch();
        test_name = "alu_then_branch";
        issue_word(make_alu(backend_pkg::op_add, 4'd3, 16'h1234, 16'h0101));
        issue_word(make_branch(backend_pkg::cond_ne, 1'b1, 16'h0005, 16'h0006, 8'h40));
        issue_word(make_alu(backend_pkg::op_xor, 4'd9, 16'hf0f0, 16'h0ff0));
        issue_word(make_branch(backend_pkg::cond_lt, 1'b0, 16'h0009, 16'h0003, 8'h7c));
        wait_drain();
    endtask

    task automatic test_alternating();
        test_name = "alternating";
        repeat (6) begin
            issue_word(random_alu());
            issue_word(random_branch());
        end
        wait_drain();
    endtask

    task automatic test_flush();
        test_name = "flush";
        // taken branch predicted not taken.
        issue_word(make_branch(backend_pkg::cond_eq, 1'b0, 16'h00aa, 16'h00aa, 8'h80));
        repeat (3) issue_word(random_alu());
        wait_drain();
        repeat (10) @(posedge clk);
        #2;
        repeat (6) issue_word(random_alu());
        wait_drain();
    endtask

    initial begin
        #((RESET_CYCLES + 200 * NUM_ISSUED) * CLK_PERIOD);
        fail_run("watchdog expired, the run hung waiting for commits");
    end

    initial begin
        void'($urandom(23));
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_instr  = '0;
        test_name    = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_alu_stream();
        test_alu_then_branch();
        test_alternating();
        test_flush();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* ooo_backend.f */
+incdir+common
common/backend_pkg.sv
reorder_buffer/reorder_buffer.sv
source/alu_unit.sv
source/branch_unit.sv
source/cdb_arbiter.sv
source/ooo_backend.sv
test/ooo_backend_chk.sv
test/ooo_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_backend_tb -f ooo_backend.f \
    --Mdir obj_dir -o sim_ooo_backend \
    && output=$(./obj_dir/sim_ooo_backend 2>&1; true) \
    && echo "$output" \
    && echo "$output" | grep -qx "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
